// File: src.f
isa_pkg.sv
pipe_pkg.sv
core_fetch.sv
core_regfile.sv
core_decode.sv
core_execute.sv
core_writeback.sv
core_top.sv
tb_clock.sv
tb_core.sv

// File: run.sh
#!/bin/sh
# build the core and its testbench with Verilator, run, and check the log
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module tb_core -f src.f &&
    ./obj_dir/Vtb_core > sim.log 2>&1 ;
cat sim.log 2>/dev/null ;
grep -q '^TESTS PASSED$' sim.log ||
    { echo "simulation did not pass, see sim.log"; exit 1; }

// File: tb_core.sv
`default_nettype none

module tb_core;
    localparam logic [31:0] RESET_PC   = 32'h1c000000;
    localparam logic [31:0] DATA_BASE  = 32'h1c010100;
    localparam int          PROG_LEN   = 200;
    localparam int          DATA_WORDS = 64;
    localparam int          TIMEOUT    = 4000;
    localparam logic [31:0] SEED       = 32'h3d995da9;

    // LoongArch la32 encodings
    localparam logic [16:0] ENC_ADD_W   = 17'h00020;
    localparam logic [16:0] ENC_SUB_W   = 17'h00022;
    localparam logic [9:0]  ENC_ADDI_W  = 10'h00a;
    localparam logic [9:0]  ENC_LD_W    = 10'h0a2;
    localparam logic [9:0]  ENC_ST_W    = 10'h0a6;
    localparam logic [6:0]  ENC_LU12I_W = 7'h0a;

    localparam int K_ADD   = 0;
    localparam int K_SUB   = 1;
    localparam int K_ADDI  = 2;
    localparam int K_LU12I = 3;
    localparam int K_LD    = 4;
    localparam int K_ST    = 5;

    logic        clk, rst_n, inst_ready, pc_valid, en, we;
    logic [31:0] pc, inst, addr, wdata, rdata;
    logic [3:0]  wmask;
    logic        commit_valid, commit_wen;
    logic [31:0] commit_pc, commit_inst, commit_wdata;
    logic [4:0]  commit_wdest;

    logic [31:0] prog [PROG_LEN];
    int          prog_kind [PROG_LEN];
    logic [31:0] exp_pc [PROG_LEN];
    logic [31:0] exp_inst [PROG_LEN];
    logic [31:0] exp_wdata [PROG_LEN];
    logic        exp_wen [PROG_LEN];
    logic [4:0]  exp_wdest [PROG_LEN];
    logic [31:0] dmem [DATA_WORDS];     // what the DUT sees
    logic [31:0] mdl_mem [DATA_WORDS];  // reference model copy

    int          commit_cnt;
    int          fetched;
    logic        fresh;
    int          value_errs;
    int          other_errs;
    logic        bp_mode;
    logic        d_en = 1'b0;
    logic        d_we = 1'b0;
    logic [31:0] d_addr = '0;
    logic [31:0] d_wdata = '0;
    logic [3:0]  d_wmask = '0;
    logic [31:0] fetch_idx, ram_idx;

    tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

    core_top #(.RESET_PC(RESET_PC)) uut (
        .clk(clk), .rst_n(rst_n), .pc(pc), .pc_valid(pc_valid),
        .inst(inst), .inst_ready(inst_ready),
        .en(en), .we(we), .addr(addr), .wmask(wmask), .wdata(wdata), .rdata(rdata),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_inst(commit_inst),
        .commit_wen(commit_wen), .commit_wdest(commit_wdest), .commit_wdata(commit_wdata)
    );

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] enc_3r(logic [16:0] op, logic [4:0] rk, logic [4:0] rj,
                                           logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(logic [9:0] op, logic [11:0] si12,
                                              logic [4:0] rj, logic [4:0] rd);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_1ri20(logic [6:0] op, logic [19:0] si20, logic [4:0] rd);
        return {op, si20, rd};
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [5:0] word_index(logic [31:0] a);
        return 6'((a - DATA_BASE) >> 2);
    endfunction

    // start value of each data word, mixes all address bits
    function automatic logic [31:0] fill_word(int k);
        logic [31:0] a;
        a = DATA_BASE + 32'(4 * k);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a5a5a;
    endfunction

    task automatic build_program();
        logic [31:0] rnd;
        logic [4:0]  rd, rj, rk;
        logic [11:0] off;
        int          kind;
        // r7 becomes the data base and is never a random destination
        prog[0]      = enc_1ri20(ENC_LU12I_W, DATA_BASE[31:12], 5'd7);
        prog_kind[0] = K_LU12I;
        prog[1]      = enc_2ri12(ENC_ADDI_W, DATA_BASE[11:0], 5'd7, 5'd7);
        prog_kind[1] = K_ADDI;
        for (int i = 2; i < PROG_LEN; i++) begin
            kind = int'($urandom_range(5, 0));
            rd   = 5'($urandom_range(6, 0));
            rj   = 5'($urandom_range(7, 0));
            rk   = 5'($urandom_range(7, 0));
            rnd  = $urandom;
            off  = {4'b0, 6'($urandom_range(63, 0)), 2'b00};
            case (kind)
                K_ADD:   prog[i] = enc_3r(ENC_ADD_W, rk, rj, rd);
                K_SUB:   prog[i] = enc_3r(ENC_SUB_W, rk, rj, rd);
                K_ADDI:  prog[i] = enc_2ri12(ENC_ADDI_W, rnd[11:0], rj, rd);
                K_LU12I: prog[i] = enc_1ri20(ENC_LU12I_W, rnd[19:0], rd);
                K_LD:    prog[i] = enc_2ri12(ENC_LD_W, off, 5'd7, rd);
                default: prog[i] = enc_2ri12(ENC_ST_W, off, 5'd7, rj);  // data from any reg
            endcase
            prog_kind[i] = kind;
        end
    endtask

    // in-order reference, one instruction at a time
    task automatic run_model();
        logic [31:0] r [32];
        logic [31:0] w, a, res;
        logic [4:0]  rd, rj, rk;
        logic        wen;
        for (int k = 0; k < 32; k++) begin
            r[k] = '0;
        end
        for (int k = 0; k < DATA_WORDS; k++) begin
            mdl_mem[k] = fill_word(k);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w   = prog[i];
            rd  = w[4:0];
            rj  = w[9:5];
            rk  = w[14:10];
            a   = r[rj] + sext12(w[21:10]);
            res = '0;
            wen = rd != 5'd0;
            case (prog_kind[i])
                K_ADD:   res = r[rj] + r[rk];
                K_SUB:   res = r[rj] - r[rk];
                K_ADDI:  res = a;
                K_LU12I: res = {w[24:5], 12'h000};
                K_LD:    res = mdl_mem[word_index(a)];
                default: begin
                    mdl_mem[word_index(a)] = r[rd];
                    wen = 1'b0;
                end
            endcase
            if (wen) begin
                r[rd] = res;
            end
            exp_pc[i]    = RESET_PC + 32'(4 * i);
            exp_inst[i]  = w;
            exp_wen[i]   = wen;
            exp_wdest[i] = rd;
            exp_wdata[i] = res;
        end
    endtask

    // data port request, sampled mid-cycle while stable
    always @(negedge clk) begin
        d_en    = en;
        d_we    = we;
        d_addr  = addr;
        d_wdata = wdata;
        d_wmask = wmask;
    end

    // inputs change a little after the rising edge
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            for (int k = 0; k < DATA_WORDS; k++) begin
                dmem[k] = fill_word(k);
            end
        end else if (d_en === 1'b1) begin
            ram_idx = (d_addr - DATA_BASE) >> 2;
            if (ram_idx >= 32'(DATA_WORDS)) begin
                other_errs++;
                $display("data access at %h falls outside the data region (time %0t)",
                         d_addr, $time);
            end else if (d_we) begin
                check("wmask", 32'(d_wmask), 32'h0000000f);
                dmem[ram_idx[5:0]] = d_wdata;
            end else begin
                rdata = dmem[ram_idx[5:0]];
            end
        end
        fetch_idx = (pc - RESET_PC) >> 2;
        if (fetch_idx < 32'(PROG_LEN)) begin
            inst       = prog[fetch_idx[7:0]];
            inst_ready = bp_mode ? 1'($urandom_range(1, 0)) : 1'b1;
        end else begin
            inst       = '0;
            inst_ready = 1'b0;  // nothing left to fetch
        end
    end

    // instruction port, pc moves by one word per transfer only
    always @(negedge clk) begin
        if (!rst_n) begin
            fetched = 0;
            fresh   = 1'b1;
        end else begin
            check("pc", pc, RESET_PC + 32'(4 * fetched));
            if (fresh) begin
                check("pc_valid", 32'(pc_valid), 32'h00000001);  // stage reg empty after reset
                fresh = 1'b0;
            end
            if (pc_valid === 1'b1 && inst_ready === 1'b1) begin
                fetched++;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            commit_cnt = 0;
        end else if (commit_valid === 1'b1) begin
            if (commit_cnt >= PROG_LEN) begin
                other_errs++;
                $display("an extra instruction committed at %0t", $time);
            end else begin
                check("commit_pc", commit_pc, exp_pc[commit_cnt]);
                check("commit_inst", commit_inst, exp_inst[commit_cnt]);
                check("commit_wen", 32'(commit_wen), 32'(exp_wen[commit_cnt]));
                if (exp_wen[commit_cnt]) begin
                    check("commit_wdest", 32'(commit_wdest), 32'(exp_wdest[commit_cnt]));
                    check("commit_wdata", commit_wdata, exp_wdata[commit_cnt]);
                end
            end
            commit_cnt++;
        end
    end

    task automatic run_program(input logic with_gaps);
        int cycles;
        #1;
        rst_n   = 1'b0;
        bp_mode = with_gaps;
        for (int c = 0; c < 2; c++) begin
            @(posedge clk);
        end
        #1;
        rst_n  = 1'b1;
        cycles = 0;
        while (commit_cnt < PROG_LEN && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (commit_cnt < PROG_LEN) begin
            other_errs++;
            $display("timed out with %0d of %0d instructions committed (fetch gaps %0b)",
                     commit_cnt, PROG_LEN, with_gaps);
        end
        // idle a little so a stray commit shows up
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
        end
        for (int k = 0; k < DATA_WORDS; k++) begin
            check($sformatf("dmem[%0d]", k), dmem[k], mdl_mem[k]);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        inst       = '0;
        inst_ready = 1'b0;
        rdata      = '0;
        bp_mode    = 1'b0;
        commit_cnt = 0;
        value_errs = 0;
        other_errs = 0;
        void'($urandom(SEED));
        build_program();
        run_model();
        run_program(1'b0);
        run_program(1'b1);  // same program, instruction port stalls at random
        $display("error count: %0d value mismatches, %0d other failures",
                 value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;  // first rising edge half a period in
    end

endmodule

`default_nettype wire

// File: core_top.sv
`default_nettype none

module core_top #(
    parameter logic [31:0] RESET_PC = 32'h1c000000
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic [31:0]       pc,
    output logic              pc_valid,
    input  logic [31:0]       inst,
    input  logic              inst_ready,
    output logic              en,
    output logic              we,
    output logic [31:0]       addr,
    output logic [3:0]        wmask,
    output logic [31:0]       wdata,
    input  logic [31:0]       rdata,
    output logic              commit_valid,
    output logic [31:0]       commit_pc,
    output logic [31:0]       commit_inst,
    output logic              commit_wen,
    output isa_pkg::reg_idx_t commit_wdest,
    output logic [31:0]       commit_wdata
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic        fd_valid, fd_ready, de_valid, de_ready, ew_valid;
    logic [31:0] fd_pc, de_pc, ew_pc;
    inst_word_t  fd_inst, de_inst, ew_inst;
    reg_idx_t    raddr1, raddr2, de_rd, ew_rd, ex_fwd_idx, wb_idx;
    logic [31:0] rdata1, rdata2, ex_fwd_data, wb_data, ew_result;
    logic [31:0] de_src_a, de_src_b, de_store_data;
    logic        de_mem_en, de_mem_we, de_wen, ew_wen;
    logic        ex_fwd_valid, ex_load_pending, wb_wen;
    alu_op_t     de_alu_op;
    wb_src_t     de_wb_src, ew_wb_src;

    core_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst_n(rst_n), .pc(pc), .pc_valid(pc_valid),
        .inst(inst), .inst_ready(inst_ready),
        .out_valid(fd_valid), .out_ready(fd_ready), .out_pc(fd_pc), .out_inst(fd_inst)
    );

    core_decode u_decode (
        .clk(clk), .rst_n(rst_n),
        .in_valid(fd_valid), .in_ready(fd_ready), .in_pc(fd_pc), .in_inst(fd_inst),
        .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
        .ex_fwd_valid(ex_fwd_valid), .ex_load_pending(ex_load_pending),
        .ex_fwd_idx(ex_fwd_idx), .ex_fwd_data(ex_fwd_data),
        .wb_wen(wb_wen), .wb_idx(wb_idx), .wb_data(wb_data),
        .out_valid(de_valid), .out_ready(de_ready), .out_pc(de_pc), .out_inst(de_inst),
        .out_alu_op(de_alu_op), .out_wb_src(de_wb_src),
        .out_src_a(de_src_a), .out_src_b(de_src_b), .out_store_data(de_store_data),
        .out_mem_en(de_mem_en), .out_mem_we(de_mem_we), .out_wen(de_wen), .out_rd(de_rd)
    );

    // writeback write lands on the same edge it is bypassed
    core_regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
        .wen(wb_wen), .waddr(wb_idx), .wdata(wb_data)
    );

    core_execute u_execute (
        .clk(clk), .rst_n(rst_n),
        .in_valid(de_valid), .in_ready(de_ready), .in_pc(de_pc), .in_inst(de_inst),
        .in_alu_op(de_alu_op), .in_wb_src(de_wb_src),
        .in_src_a(de_src_a), .in_src_b(de_src_b), .in_store_data(de_store_data),
        .in_mem_en(de_mem_en), .in_mem_we(de_mem_we), .in_wen(de_wen), .in_rd(de_rd),
        .en(en), .we(we), .addr(addr), .wmask(wmask), .wdata(wdata),
        .ex_fwd_valid(ex_fwd_valid), .ex_load_pending(ex_load_pending),
        .ex_fwd_idx(ex_fwd_idx), .ex_fwd_data(ex_fwd_data),
        .out_valid(ew_valid), .out_pc(ew_pc), .out_inst(ew_inst), .out_wen(ew_wen),
        .out_rd(ew_rd), .out_wb_src(ew_wb_src), .out_result(ew_result)
    );

    core_writeback u_writeback (
        .clk(clk), .rst_n(rst_n),
        .in_valid(ew_valid), .in_pc(ew_pc), .in_inst(ew_inst), .in_wen(ew_wen),
        .in_rd(ew_rd), .in_wb_src(ew_wb_src), .in_result(ew_result), .rdata(rdata),
        .wb_wen(wb_wen), .wb_idx(wb_idx), .wb_data(wb_data),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_inst(commit_inst),
        .commit_wen(commit_wen), .commit_wdest(commit_wdest), .commit_wdata(commit_wdata)
    );

endmodule

`default_nettype wire

// File: core_writeback.sv
`default_nettype none

module core_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic [31:0]         in_pc,
    input  isa_pkg::inst_word_t in_inst,
    input  logic                in_wen,
    input  isa_pkg::reg_idx_t   in_rd,
    input  pipe_pkg::wb_src_t   in_wb_src,
    input  logic [31:0]         in_result,
    input  logic [31:0]         rdata,
    output logic                wb_wen,
    output isa_pkg::reg_idx_t   wb_idx,
    output logic [31:0]         wb_data,
    output logic                commit_valid,
    output logic [31:0]         commit_pc,
    output logic [31:0]         commit_inst,
    output logic                commit_wen,
    output isa_pkg::reg_idx_t   commit_wdest,
    output logic [31:0]         commit_wdata
);
    import pipe_pkg::*;

    assign wb_wen  = in_valid && in_wen && in_rd != '0;
    assign wb_idx  = in_rd;
    assign wb_data = (in_wb_src == WB_LOAD) ? rdata : in_result;  // ram answers a cycle after en

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        commit_pc    <= in_pc;
        commit_inst  <= in_inst;
        commit_wen   <= wb_wen;
        commit_wdest <= in_rd;
        commit_wdata <= wb_data;
    end

    // every load carries a destination, even r0
    a_load_writes: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_wb_src == WB_LOAD |-> in_wen);

    // a held item must not be passed on twice
    a_no_repeat: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && $past(in_valid) |-> in_pc != $past(in_pc));

endmodule

`default_nettype wire

// File: core_execute.sv
`default_nettype none

module core_execute (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [31:0]         in_pc,
    input  isa_pkg::inst_word_t in_inst,
    input  pipe_pkg::alu_op_t   in_alu_op,
    input  pipe_pkg::wb_src_t   in_wb_src,
    input  logic [31:0]         in_src_a,
    input  logic [31:0]         in_src_b,
    input  logic [31:0]         in_store_data,
    input  logic                in_mem_en,
    input  logic                in_mem_we,
    input  logic                in_wen,
    input  isa_pkg::reg_idx_t   in_rd,
    output logic                en,
    output logic                we,
    output logic [31:0]         addr,
    output logic [3:0]          wmask,
    output logic [31:0]         wdata,
    output logic                ex_fwd_valid,
    output logic                ex_load_pending,
    output isa_pkg::reg_idx_t   ex_fwd_idx,
    output logic [31:0]         ex_fwd_data,
    output logic                out_valid,
    output logic [31:0]         out_pc,
    output isa_pkg::inst_word_t out_inst,
    output logic                out_wen,
    output isa_pkg::reg_idx_t   out_rd,
    output pipe_pkg::wb_src_t   out_wb_src,
    output logic [31:0]         out_result
);
    import pipe_pkg::*;

    logic [31:0] alu;
    logic        fire;
    logic        writes_rd;

    always_comb begin
        case (in_alu_op)
            ALU_ADD:    alu = in_src_a + in_src_b;
            ALU_SUB:    alu = in_src_a - in_src_b;
            ALU_PASS_B: alu = in_src_b;
            default:    alu = in_src_b;
        endcase
    end

    assign in_ready = 1'b1;  // writeback never stalls
    assign fire     = in_valid && in_ready;

    // data port, request goes out with the transfer
    assign en    = fire && in_mem_en;
    assign we    = fire && in_mem_we;
    assign addr  = alu;
    assign wmask = we ? 4'hf : 4'h0;
    assign wdata = in_store_data;

    assign writes_rd       = in_valid && in_wen && in_rd != '0;
    assign ex_fwd_valid    = writes_rd && in_wb_src == WB_ALU;
    assign ex_load_pending = writes_rd && in_wb_src == WB_LOAD;
    assign ex_fwd_idx      = in_rd;
    assign ex_fwd_data     = alu;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_pc     <= in_pc;
            out_inst   <= in_inst;
            out_wen    <= in_wen;
            out_rd     <= in_rd;
            out_wb_src <= in_wb_src;
            out_result <= alu;
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        en |-> addr[1:0] == 2'b00);

    // rdata lines up with the load sitting in writeback
    a_load_follows: assert property (@(posedge clk) disable iff (!rst_n)
        en && !we |=> out_valid && out_wb_src == WB_LOAD);

endmodule

`default_nettype wire

// File: core_decode.sv
`default_nettype none

module core_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [31:0]         in_pc,
    input  isa_pkg::inst_word_t in_inst,
    output isa_pkg::reg_idx_t   raddr1,
    output isa_pkg::reg_idx_t   raddr2,
    input  logic [31:0]         rdata1,
    input  logic [31:0]         rdata2,
    input  logic                ex_fwd_valid,
    input  logic                ex_load_pending,
    input  isa_pkg::reg_idx_t   ex_fwd_idx,
    input  logic [31:0]         ex_fwd_data,
    input  logic                wb_wen,
    input  isa_pkg::reg_idx_t   wb_idx,
    input  logic [31:0]         wb_data,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [31:0]         out_pc,
    output isa_pkg::inst_word_t out_inst,
    output pipe_pkg::alu_op_t   out_alu_op,
    output pipe_pkg::wb_src_t   out_wb_src,
    output logic [31:0]         out_src_a,
    output logic [31:0]         out_src_b,
    output logic [31:0]         out_store_data,
    output logic                out_mem_en,
    output logic                out_mem_we,
    output logic                out_wen,
    output isa_pkg::reg_idx_t   out_rd
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic        is_add, is_sub, is_addi, is_ld, is_st, is_lu12i;
    logic        match_3r, match_2ri12, match_1ri20;
    logic        use_a, use_b, stall, fire;
    logic [31:0] opa, opb, imm;
    alu_op_t     alu_op;

    assign is_add    = in_inst.fmt_3r.opcode == OP_ADD_W;
    assign is_sub    = in_inst.fmt_3r.opcode == OP_SUB_W;
    assign is_addi   = in_inst.fmt_2ri12.opcode == OP_ADDI_W;
    assign is_ld     = in_inst.fmt_2ri12.opcode == OP_LD_W;
    assign is_st     = in_inst.fmt_2ri12.opcode == OP_ST_W;
    assign is_lu12i  = in_inst.fmt_1ri20.opcode == OP_LU12I_W;

    assign match_3r    = is_add | is_sub;
    assign match_2ri12 = is_addi | is_ld | is_st;
    assign match_1ri20 = is_lu12i;

    assign raddr1 = in_inst.fmt_3r.rj;  // same bits in the 2ri12 view
    assign raddr2 = match_3r ? in_inst.fmt_3r.rk : in_inst.fmt_2ri12.rd;  // st.w data is rd
    assign use_a  = match_3r | match_2ri12;
    assign use_b  = match_3r | is_st;

    // execute beats writeback beats the register file
    assign opa = (ex_fwd_valid && ex_fwd_idx == raddr1) ? ex_fwd_data :
                 (wb_wen && wb_idx == raddr1)           ? wb_data     : rdata1;
    assign opb = (ex_fwd_valid && ex_fwd_idx == raddr2) ? ex_fwd_data :
                 (wb_wen && wb_idx == raddr2)           ? wb_data     : rdata2;

    // load result not ready until it reaches writeback
    assign stall = ex_load_pending &&
                   ((use_a && ex_fwd_idx == raddr1) || (use_b && ex_fwd_idx == raddr2));

    assign imm = is_lu12i ? {in_inst.fmt_1ri20.si20, 12'b0}
                          : {{20{in_inst.fmt_2ri12.si12[11]}}, in_inst.fmt_2ri12.si12};
    assign alu_op = is_sub ? ALU_SUB : (is_lu12i ? ALU_PASS_B : ALU_ADD);

    assign in_ready = (!out_valid || out_ready) && !stall;
    assign fire     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_pc         <= in_pc;
            out_inst       <= in_inst;
            out_alu_op     <= alu_op;
            out_wb_src     <= is_ld ? WB_LOAD : WB_ALU;
            out_src_a      <= opa;
            out_src_b      <= match_3r ? opb : imm;
            out_store_data <= opb;
            out_mem_en     <= is_ld | is_st;
            out_mem_we     <= is_st;
            out_wen        <= match_3r | is_addi | is_ld | is_lu12i;  // unknown words write nothing
            out_rd         <= in_inst.fmt_3r.rd;
        end
    end

    a_one_view: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> $onehot0({match_3r, match_2ri12, match_1ri20}));

    // the load moves on at once, so a load-use bubble is a single cycle
    a_stall_once: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && stall |=> !stall);

    a_in_held: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_inst));

endmodule

`default_nettype wire

// File: core_regfile.sv
`default_nettype none

module core_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t raddr1,
    input  isa_pkg::reg_idx_t raddr2,
    output logic [31:0]       rdata1,
    output logic [31:0]       rdata2,
    input  logic              wen,
    input  isa_pkg::reg_idx_t waddr,
    input  logic [31:0]       wdata
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero whatever was written
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: core_fetch.sv
`default_nettype none

module core_fetch #(
    parameter logic [31:0] RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    output logic [31:0]         pc,
    output logic                pc_valid,
    input  logic [31:0]         inst,
    input  logic                inst_ready,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [31:0]         out_pc,
    output isa_pkg::inst_word_t out_inst
);
    logic [31:0] pc_q;
    logic        fire;

    assign pc       = pc_q;
    assign pc_valid = !out_valid || out_ready;  // stage reg free or draining
    assign fire     = pc_valid && inst_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q      <= RESET_PC;
            out_valid <= 1'b0;
        end else begin
            if (fire) begin
                pc_q <= pc_q + 32'd4;
            end
            if (fire) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // inst memory is combinational, word is good in the fire cycle
    always_ff @(posedge clk) begin
        if (fire) begin
            out_pc   <= pc_q;
            out_inst <= inst;
        end
    end

    a_hold_inst: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_inst) && $stable(out_pc));

endmodule

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_PASS_B   // lu12i.w, immediate goes straight through
    } alu_op_t;

    typedef enum logic {
        WB_ALU,
        WB_LOAD
    } wb_src_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [4:0] reg_idx_t;

    // 3R format: add.w, sub.w
    typedef struct packed {
        logic [16:0] opcode;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_3r_t;

    // 2RI12 format: addi.w, ld.w, st.w
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_2ri12_t;

    // 1RI20 format: lu12i.w
    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] si20;
        reg_idx_t    rd;
    } fmt_1ri20_t;

    // one fetched word, read through whichever view its opcode matches
    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_1ri20_t fmt_1ri20;
    } inst_word_t;

    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [9:0]  OP_ADDI_W  = 10'h00a;
    localparam logic [9:0]  OP_LD_W    = 10'h0a2;
    localparam logic [9:0]  OP_ST_W    = 10'h0a6;
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;

endpackage

`default_nettype wire
